// ==== sim.f ====
hw/core_cfg_pkg.sv
hw/core_types_pkg.sv
hw/credit_fifo.sv
hw/act_gbf.sv
hw/act_dispatch.sv
hw/sparse_pe.sv
hw/psum_collect.sv
hw/sparse_core_top.sv
tb/tb_sparse_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sparse_core
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_sparse_core.sv ====
// sparse core testbench: random blocks against a reference model, assertion checks
module tb_sparse_core;

    timeunit 1ns;
    timeprecision 1ps;

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    // blocks written per test, the fill test capped at N_FILL plus N_OVER
    localparam int N_DENSE     = 8;
    localparam int N_SPARSE    = 12;
    localparam int N_RAND      = 16;
    localparam int N_FILL      = 40;
    localparam int N_OVER      = 4;
    localparam int N_BATCH     = 4;
    localparam int N_BLOCKS    = N_DENSE + N_SPARSE + N_RAND + N_FILL + N_OVER + 2 * N_BATCH;
    localparam int WD_CYCLES   = 200 * N_BLOCKS + 1000;
    localparam int DRAIN_LIMIT = 2000;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      act_wr_en;
    act_blk_t  act_wr;
    logic      act_full;
    wei_load_t wei_load;
    logic      out_valid;
    logic      out_ready;
    result_t   out_res;

    logic [31:0] lfsr_state = 32'h5cf66db3;
    data_t       wei_ref [NUM_PE][BLOCK_DEPTH];
    result_t     exp_q [$];
    result_t     exp_r;
    bit          rand_ready;
    int          err_cnt;
    int          n_results;
    int          n_tests;
    int          err_before;

    sparse_core_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .act_wr_en (act_wr_en),
        .act_wr    (act_wr),
        .act_full  (act_full),
        .wei_load  (wei_load),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    always #5 clk = ~clk;

    // ============================================================
    // stimulus helpers and reference model
    // ============================================================
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    function automatic act_blk_t rand_blk(input bit dense, input bit zero_flags);
        act_blk_t    b;
        logic [31:0] r;
        if (dense) begin
            b.flag = '1;
        end else if (zero_flags) begin
            b.flag = '0;
        end else begin
            r      = lfsr_bits(BLOCK_DEPTH);
            b.flag = r[BLOCK_DEPTH-1:0];
        end
        // unflagged lanes carry junk too
        for (int l = 0; l < BLOCK_DEPTH; l++) begin
            r        = lfsr_bits(DATA_WIDTH);
            b.act[l] = r[DATA_WIDTH-1:0];
        end
        return b;
    endfunction

    function automatic result_t expect_res(input act_blk_t b, input int pe);
        result_t r;
        int      s;
        s = 0;
        for (int l = 0; l < BLOCK_DEPTH; l++) begin
            if (b.flag[l]) begin
                s = s + int'($signed(b.act[l])) * int'(wei_ref[pe][l]);
            end
        end
        r.pe_idx = PE_IDX_WIDTH'(pe);
        r.psum   = PSUM_WIDTH'(s);
        return r;
    endfunction

    task automatic step();
        logic [31:0] r;
        @(negedge clk);
        if (rand_ready) begin
            r         = lfsr_bits(1);
            out_ready = r[0];
        end
    endtask

    task automatic write_blk(input act_blk_t b, input bit wait_room);
        if (wait_room) begin
            while (act_full) begin
                step();
            end
        end
        act_wr_en = 1'b1;
        act_wr    = b;
        step();
        act_wr_en = 1'b0;
    endtask

    task automatic load_weights();
        logic [31:0] r;
        for (int p = 0; p < NUM_PE; p++) begin
            wei_load.en     = 1'b1;
            wei_load.pe_idx = PE_IDX_WIDTH'(p);
            for (int l = 0; l < BLOCK_DEPTH; l++) begin
                r               = lfsr_bits(DATA_WIDTH);
                wei_load.wei[l] = r[DATA_WIDTH-1:0];
                wei_ref[p][l]   = r[DATA_WIDTH-1:0];
            end
            step();
        end
        wei_load.en = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            step();
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d expected results never arrived", exp_q.size());
            err_cnt++;
        end
        repeat (20) step();
        assert (!out_valid) else begin
            $display("a result appeared after all expected results were taken");
            err_cnt++;
        end
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, err_cnt - err_before);
        n_tests++;
        err_before = err_cnt;
    endtask

    // ============================================================
    // checkers
    // ============================================================
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("element %0d sent a result with no block outstanding", out_res.pe_idx);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_r = exp_q.pop_front();
                n_results++;
                assert (out_res == exp_r) else begin
                    $display("ERR %0t: got pe %0d psum %0d, expected pe %0d psum %0d", $time,
                             out_res.pe_idx, $signed(out_res.psum),
                             exp_r.pe_idx, $signed(exp_r.psum));
                    err_cnt++;
                end
            end
        end
        // accepted writes become expected results, one per element
        if (rst_n && act_wr_en && !act_full) begin
            for (int p = 0; p < NUM_PE; p++) begin
                exp_q.push_back(expect_res(act_wr, p));
            end
        end
    end

    held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_res)))
    else begin
        $display("ERR %0t: stalled result changed or was withdrawn", $time);
        err_cnt++;
    end

    initial begin
        #(WD_CYCLES * 10);
        $display("watchdog: run did not finish within %0d cycles", WD_CYCLES);
        $display("Errors found");
        $finish;
    end

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        rst_n     = 1'b0;
        act_wr_en = 1'b0;
        act_wr    = '0;
        wei_load  = '0;
        out_ready = 1'b1;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        step();
        assert (!out_valid && !act_full) else begin
            $display("out_valid or act_full high after reset");
            err_cnt++;
        end
        report(1, "reset state");

        load_weights();
        for (int i = 0; i < N_DENSE; i++) write_blk(rand_blk(1'b1, 1'b0), 1'b1);
        drain();
        report(2, "dense blocks");

        // every fourth block has no flag set
        for (int i = 0; i < N_SPARSE; i++) write_blk(rand_blk(1'b0, (i % 4) == 0), 1'b1);
        drain();
        report(3, "sparse blocks");

        rand_ready = 1'b1;
        for (int i = 0; i < N_RAND; i++) write_blk(rand_blk(1'b0, 1'b0), 1'b1);
        drain();
        rand_ready = 1'b0;
        out_ready  = 1'b1;
        report(4, "random out_ready");

        out_ready = 1'b0;
        for (int i = 0; i < N_FILL && !act_full; i++) write_blk(rand_blk(1'b0, 1'b0), 1'b0);
        assert (act_full) else begin
            $display("buffer never reported full while the output was stalled");
            err_cnt++;
        end
        for (int i = 0; i < N_OVER; i++) begin
            assert (act_full) else begin
                $display("full flag dropped while the output was stalled");
                err_cnt++;
            end
            write_blk(rand_blk(1'b0, 1'b0), 1'b0);
        end
        out_ready = 1'b1;
        drain();
        report(5, "back-pressure fill");

        for (int b = 0; b < 2; b++) begin
            load_weights();
            for (int i = 0; i < N_BATCH; i++) write_blk(rand_blk(1'b0, 1'b0), 1'b1);
            drain();
        end
        report(6, "weight reload");

        $display("%0d tests, %0d results checked, %0d errors", n_tests, n_results, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== hw/sparse_core_top.sv ====
// sparse core top: buffer, dispatcher, element array and collector
module sparse_core_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      act_wr_en,
    input  core_types_pkg::act_blk_t  act_wr,
    output logic                      act_full,
    input  core_types_pkg::wei_load_t wei_load,
    output logic                      out_valid,
    input  logic                      out_ready,
    output core_types_pkg::result_t   out_res
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    logic               gbf_empty;
    logic               gbf_rd_en;
    act_blk_t           gbf_rd_blk;
    logic               blk_valid;
    act_blk_t           blk;
    logic [NUM_PE-1:0]  act_credit;
    logic [NUM_PE-1:0]  res_credit;
    logic [NUM_PE-1:0]  psum_valid;
    psum_t [NUM_PE-1:0] psum;

    act_gbf i_gbf (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (act_wr_en),
        .wr_blk (act_wr),
        .full   (act_full),
        .rd_en  (gbf_rd_en),
        .rd_blk (gbf_rd_blk),
        .empty  (gbf_empty)
    );

    act_dispatch i_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .gbf_empty  (gbf_empty),
        .rd_en      (gbf_rd_en),
        .rd_blk     (gbf_rd_blk),
        .act_credit (act_credit),
        .blk_valid  (blk_valid),
        .blk        (blk)
    );

    // ============================================================
    // element array
    // ============================================================
    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        sparse_pe #(
            .PE_IDX (i)
        ) i_pe (
            .clk        (clk),
            .rst_n      (rst_n),
            .wei_load   (wei_load),
            .blk_valid  (blk_valid),
            .blk        (blk),
            .act_credit (act_credit[i]),
            .res_credit (res_credit[i]),
            .psum_valid (psum_valid[i]),
            .psum       (psum[i])
        );
    end

    psum_collect i_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .psum_valid (psum_valid),
        .psum       (psum),
        .res_credit (res_credit),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_res    (out_res)
    );

endmodule

// ==== hw/psum_collect.sv ====
// partial-sum collector: per-element queues drained in element order
module psum_collect (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [core_cfg_pkg::NUM_PE-1:0]              psum_valid,
    input  core_types_pkg::psum_t [core_cfg_pkg::NUM_PE-1:0] psum,
    output logic [core_cfg_pkg::NUM_PE-1:0]              res_credit,
    output logic                                         out_valid,
    input  logic                                         out_ready,
    output core_types_pkg::result_t                      out_res
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    logic [PE_IDX_WIDTH-1:0] ptr;
    psum_t [NUM_PE-1:0]      q_item;
    logic  [NUM_PE-1:0]      q_not_empty;
    logic  [NUM_PE-1:0]      q_pop;
    logic                    accept;

    // ============================================================
    // one queue per element
    // ============================================================
    for (genvar i = 0; i < NUM_PE; i++) begin : g_queue
        assign q_pop[i] = accept && (ptr == PE_IDX_WIDTH'(i));

        credit_fifo #(
            .item_t (psum_t),
            .DEPTH  (PE_CREDITS)
        ) i_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (psum_valid[i]),
            .push_item (psum[i]),
            .pop       (q_pop[i]),
            .pop_item  (q_item[i]),
            .not_empty (q_not_empty[i]),
            .credit    (res_credit[i])
        );
    end

    // output stays on the pointed queue until it is taken
    assign out_valid      = q_not_empty[ptr];
    assign out_res.pe_idx = ptr;
    assign out_res.psum   = q_item[ptr];
    assign accept         = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (accept) begin
            ptr <= (ptr == PE_IDX_WIDTH'(NUM_PE - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

// ==== hw/sparse_pe.sv ====
// sparse processing element: zero-skipping multiply-accumulate of a block
module sparse_pe #(
    parameter int PE_IDX = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_types_pkg::wei_load_t wei_load,
    input  logic                      blk_valid,
    input  core_types_pkg::act_blk_t  blk,
    output logic                      act_credit,
    input  logic                      res_credit,
    output logic                      psum_valid,
    output core_types_pkg::psum_t     psum
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MAC,
        S_DONE
    } state_t;

    state_t                        state;
    data_t [BLOCK_DEPTH-1:0]       wei;
    data_t [BLOCK_DEPTH-1:0]       cur_act;
    logic  [BLOCK_DEPTH-1:0]       pend;
    logic  [BLOCK_DEPTH-1:0]       onehot;
    logic signed [2*DATA_WIDTH-1:0] prod;
    psum_t                         acc;
    logic  [CREDIT_WIDTH-1:0]      out_cnt;
    act_blk_t                      q_blk;
    logic                          q_not_empty;
    logic                          pop;
    logic                          last_lane;

    credit_fifo #(
        .item_t (act_blk_t),
        .DEPTH  (PE_CREDITS)
    ) i_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (blk_valid),
        .push_item (blk),
        .pop       (pop),
        .pop_item  (q_blk),
        .not_empty (q_not_empty),
        .credit    (act_credit)
    );

    always_ff @(posedge clk) begin
        if (wei_load.en && (wei_load.pe_idx == PE_IDX_WIDTH'(PE_IDX))) begin
            wei <= wei_load.wei;
        end
    end

    // ============================================================
    // lane walk
    // ============================================================
    // lowest pending lane first
    always_comb begin
        onehot = pend & (~pend + 1'b1);
        prod   = '0;
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            if (onehot[i]) begin
                prod = cur_act[i] * wei[i];
            end
        end
    end

    assign last_lane  = ((pend & ~onehot) == '0);
    assign psum_valid = (state == S_DONE) && (out_cnt != '0);
    assign psum       = acc;
    // next block can start in the same cycle the finished sum leaves
    assign pop        = ((state == S_IDLE) || psum_valid) && q_not_empty;

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_act <= q_blk.act;
            acc     <= '0;
        end else if (state == S_MAC) begin
            acc <= acc + psum_t'(prod);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            pend  <= '0;
        end else if (pop) begin
            state <= S_MAC;
            pend  <= q_blk.flag;
        end else if (psum_valid) begin
            state <= S_IDLE;
        end else if (state == S_MAC) begin
            pend <= pend & ~onehot;
            // an all-zero block still spends one cycle here
            if (last_lane) begin
                state <= S_DONE;
            end
        end
    end

    // credits toward the collector queue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt <= CREDIT_WIDTH'(PE_CREDITS);
        end else begin
            case ({psum_valid, res_credit})
                2'b10:   out_cnt <= out_cnt - 1'b1;
                2'b01:   out_cnt <= out_cnt + 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

endmodule

// ==== hw/act_dispatch.sv ====
// activation dispatcher: credit-gated buffer reads broadcast to every element
module act_dispatch (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             gbf_empty,
    output logic                             rd_en,
    input  core_types_pkg::act_blk_t         rd_blk,
    input  logic [core_cfg_pkg::NUM_PE-1:0]  act_credit,
    output logic                             blk_valid,
    output core_types_pkg::act_blk_t         blk
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    logic [CREDIT_WIDTH-1:0] cnt [NUM_PE];
    logic                    all_credit;

    // every element must have room before a block leaves the buffer
    always_comb begin
        all_credit = 1'b1;
        for (int i = 0; i < NUM_PE; i++) begin
            if (cnt[i] == '0) begin
                all_credit = 1'b0;
            end
        end
    end

    assign rd_en = !gbf_empty && all_credit;

    // buffer data lands one cycle after rd_en, lined up with blk_valid
    assign blk = rd_blk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_valid <= 1'b0;
        end else begin
            blk_valid <= rd_en;
        end
    end

    // ============================================================
    // per-element credit counters
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PE; i++) begin
                cnt[i] <= CREDIT_WIDTH'(PE_CREDITS);
            end
        end else begin
            for (int i = 0; i < NUM_PE; i++) begin
                case ({rd_en, act_credit[i]})
                    2'b10:   cnt[i] <= cnt[i] - 1'b1;
                    2'b01:   cnt[i] <= cnt[i] + 1'b1;
                    default: cnt[i] <= cnt[i];
                endcase
            end
        end
    end

endmodule

// ==== hw/act_gbf.sv ====
// activation global buffer: circular block store with occupancy and registered read
module act_gbf (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  core_types_pkg::act_blk_t wr_blk,
    output logic                     full,
    input  logic                     rd_en,
    output core_types_pkg::act_blk_t rd_blk,
    output logic                     empty
);

    import core_cfg_pkg::*;
    import core_types_pkg::*;

    act_blk_t                  mem [GBF_DEPTH];
    logic [GBF_ADDR_WIDTH-1:0] wr_ptr;
    logic [GBF_ADDR_WIDTH-1:0] rd_ptr;
    logic [GBF_ADDR_WIDTH:0]   count;
    logic                      wr_ok;
    logic                      rd_ok;

    // writes while full are dropped
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;
    assign full  = (count == (GBF_ADDR_WIDTH + 1)'(GBF_DEPTH));
    assign empty = (count == '0);

    // ============================================================
    // storage and read port
    // ============================================================
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_blk;
        end
        if (rd_ok) begin
            rd_blk <= mem[rd_ptr];
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/credit_fifo.sv ====
// credit fifo: small register queue that returns one credit per pop
module credit_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t pop_item,
    output logic  not_empty,
    output logic  credit
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // no full check, the sender never pushes without a credit
    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign pop_item  = mem[rd_ptr];
    assign credit    = do_pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/core_types_pkg.sv ====
// core types: packed payloads passed between buffer, elements and collector
package core_types_pkg;

    import core_cfg_pkg::*;

    // one signed activation or weight
    typedef logic signed [DATA_WIDTH-1:0] data_t;

    // one partial sum
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    // flagged activation block, one buffer word
    typedef struct packed {
        logic [BLOCK_DEPTH-1:0]  flag;
        data_t [BLOCK_DEPTH-1:0] act;
    } act_blk_t;

    // weight load broadcast, taken by the element whose index matches
    typedef struct packed {
        logic                    en;
        logic [PE_IDX_WIDTH-1:0] pe_idx;
        data_t [BLOCK_DEPTH-1:0] wei;
    } wei_load_t;

    // tagged result toward the output port
    typedef struct packed {
        logic [PE_IDX_WIDTH-1:0] pe_idx;
        psum_t                   psum;
    } result_t;

endpackage

// ==== hw/core_cfg_pkg.sv ====
// core config: sizes, depths and credit counts of the sparse convolution core
package core_cfg_pkg;

    // ============================================================
    // datapath
    // ============================================================
    localparam int DATA_WIDTH     = 8;
    localparam int BLOCK_DEPTH    = 4;
    localparam int NUM_PE         = 4;
    localparam int PSUM_WIDTH     = 20;
    localparam int PE_IDX_WIDTH   = 2;

    // ============================================================
    // buffering and credit links
    // ============================================================
    localparam int GBF_DEPTH      = 16;
    localparam int GBF_ADDR_WIDTH = 4;
    // queue depth equals the initial credit count on both links
    localparam int PE_CREDITS     = 2;
    // wide enough to hold 0 .. PE_CREDITS
    localparam int CREDIT_WIDTH   = 2;

endpackage
